/* common/cache_pkg.sv */
// ------------------------------
// shared types for the CPU-side cache: word and address widths,
// request and memory command structs, TLB entry layout and the
// controller state encoding; modules import it inside their body
// ------------------------------
`default_nettype none

package cache_pkg;

  // ------------------------------
  // sizes
  // ------------------------------
  localparam int LINES       = 256;          // direct mapped, one word per line
  localparam int TLB_ENTRIES = 256;

  // ------------------------------
  // widths and address fields
  // ------------------------------
  typedef logic [31:0] word_t;
  typedef logic [31:0] vaddr_t;              // word address, CPU side
  typedef logic [31:0] paddr_t;              // word address, memory side
  typedef logic [7:0]  line_idx_t;           // addr 7:0
  typedef logic [7:0]  tlb_idx_t;            // addr 15:8
  typedef logic [15:0] page_tag_t;           // addr 31:16
  typedef logic [23:0] cache_tag_t;          // {ptag, tlb index}

  // ------------------------------
  // structs
  // ------------------------------
  // for a TLB write wdata is {ptag, vtag}
  typedef struct packed {
    vaddr_t addr;
    word_t  wdata;
    logic   we;
  } cpu_req_s;

  typedef struct packed {
    paddr_t addr;
    word_t  wdata;
    logic   we;
  } mem_cmd_s;

  typedef struct packed {
    page_tag_t ptag;
    page_tag_t vtag;
  } tlb_entry_s;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,                                  // arrays read
    CHECK,                                   // hit and fault valid
    WRITE_MEM,
    FILL,
    BYPASS,
    TLB_LOAD
  } ctrl_state_e;

endpackage

`default_nettype wire

/* design/fill_counter.sv */
// ------------------------------
// word offset for a two-word block fill. starts at the requested
// word and flips to its pair, last marks the second word
// ------------------------------
`default_nettype none

module fill_counter (
  input  wire logic  CPU_CLK,
  input  wire logic  RST,
  input  wire logic  start,
  input  wire logic  first_offset,
  input  wire logic  step,
  output logic       offset,
  output logic       last
);
  logic second;                               // on the pair word

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      offset <= 1'b0;
      second <= 1'b0;
    end
    else if (start)
    begin
      offset <= first_offset;
      second <= 1'b0;
    end
    else if (step)
    begin
      offset <= ~offset;
      second <= 1'b1;
    end
  end

  assign last = second;

endmodule

`default_nettype wire

/* design/mem_port.sv */
// ------------------------------
// four-phase req/ack master. latches one command on start, drops
// req on ack, and pulses done once ack has fallen again
// ------------------------------
`default_nettype none

module mem_port (
  input  wire logic                 CPU_CLK,
  input  wire logic                 RST,
  input  wire logic                 start,
  input  wire cache_pkg::mem_cmd_s  cmd_in,
  input  wire logic                 mem_ack,
  input  wire cache_pkg::word_t     mem_rdata,
  output cache_pkg::mem_cmd_s       mem_cmd,
  output logic                      mem_req,
  output logic                      done,
  output cache_pkg::word_t          rdata_cap
);
  logic wait_fall;                            // req dropped, ack still high
  logic idle;
  logic launch;

  assign idle   = !mem_req && !wait_fall && !mem_ack;
  assign launch = start && idle;

  // ------------------------------
  // handshake
  // ------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      mem_req   <= 1'b0;
      wait_fall <= 1'b0;
      done      <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      if (launch)
        mem_req <= 1'b1;
      else if (mem_req && mem_ack)
      begin
        mem_req   <= 1'b0;
        wait_fall <= 1'b1;
      end
      else if (wait_fall && !mem_ack)
      begin
        wait_fall <= 1'b0;
        done      <= 1'b1;
      end
    end
  end

  // command held stable until the next launch
  always_ff @(posedge CPU_CLK)
  begin
    if (launch)
      mem_cmd <= cmd_in;
    if (mem_req && mem_ack)
      rdata_cap <= mem_rdata;                 // valid while ack is high
  end

endmodule

`default_nettype wire

/* design/tlb_store.sv */
// ------------------------------
// translation table. one entry read per lookup, written whole on
// a TLB load. with vmem off it passes the virtual tag through
// ------------------------------
`default_nettype none

module tlb_store (
  input  wire logic                   CPU_CLK,
  input  wire logic                   re,
  input  wire cache_pkg::tlb_idx_t    rd_idx,
  input  wire cache_pkg::page_tag_t   vtag,
  input  wire logic                   vmem,
  input  wire logic                   we,
  input  wire cache_pkg::tlb_idx_t    wr_idx,
  input  wire cache_pkg::tlb_entry_s  wr_entry,
  output cache_pkg::page_tag_t        ptag,
  output logic                        fault
);
  import cache_pkg::*;

  tlb_entry_s entry_mem [TLB_ENTRIES];
  tlb_entry_s entry_q;                        // entry of the current lookup

  always_ff @(posedge CPU_CLK)
  begin
    if (we)
      entry_mem[wr_idx] <= wr_entry;
    if (re)
      entry_q <= entry_mem[rd_idx];
  end

  assign fault = vmem && (entry_q.vtag != vtag);   // stale or foreign page
  assign ptag  = vmem ? entry_q.ptag : vtag;

endmodule

`default_nettype wire

/* cache/cache_store.sv */
// ------------------------------
// cache data and tag arrays, one word per line. read is registered
// on re, hit compares the registered tag against want_tag
// ------------------------------
`default_nettype none

module cache_store (
  input  wire logic                   CPU_CLK,
  input  wire logic                   RST,
  input  wire logic                   re,
  input  wire cache_pkg::line_idx_t   rd_idx,
  input  wire cache_pkg::cache_tag_t  want_tag,
  input  wire logic                   we,
  input  wire cache_pkg::line_idx_t   wr_idx,
  input  wire cache_pkg::cache_tag_t  wr_tag,
  input  wire cache_pkg::word_t       wr_data,
  output cache_pkg::word_t            rd_data,
  output logic                        hit
);
  import cache_pkg::*;

  word_t            data_mem [LINES];
  cache_tag_t       tag_mem  [LINES];
  logic [LINES-1:0] valid;
  cache_tag_t       tag_q;
  logic             valid_q;

  // ------------------------------
  // arrays
  // ------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (we)
    begin
      data_mem[wr_idx] <= wr_data;
      tag_mem[wr_idx]  <= wr_tag;
    end
    if (re)
    begin
      rd_data <= data_mem[rd_idx];
      tag_q   <= tag_mem[rd_idx];
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      valid   <= '0;                          // empty cache
      valid_q <= 1'b0;
    end
    else
    begin
      if (we)
        valid[wr_idx] <= 1'b1;
      if (re)
        valid_q <= valid[rd_idx];
    end
  end

  assign hit = valid_q && (tag_q == want_tag);

endmodule

`default_nettype wire

/* cache/cache_ctrl.sv */
// ------------------------------
// cache controller FSM. accepts one CPU access at a time, walks
// lookup and check, then ends on a hit or fault or starts a
// write-through, a two-word fill or a bypass read via the memory port
// ------------------------------
`default_nettype none

module cache_ctrl (
  input  wire logic                  CPU_CLK,
  input  wire logic                  RST,
  input  wire logic                  cpu_enable,
  input  wire cache_pkg::cpu_req_s   cpu_req,
  input  wire logic                  tlb_we,
  input  wire logic                  vmem_act,
  input  wire logic                  cache_inhibit,
  input  wire logic                  hit,
  input  wire logic                  fault,
  input  wire cache_pkg::page_tag_t  ptag,
  input  wire logic                  mem_done,
  input  wire cache_pkg::word_t      mem_rdata_cap,
  input  wire logic                  fill_offset,
  input  wire logic                  fill_last,
  input  wire cache_pkg::word_t      line_data,
  output logic                       cpu_busy,
  output cache_pkg::word_t           cpu_rdata,
  output logic                       mmu_fault,
  output logic                       vmem,
  output cache_pkg::page_tag_t       req_vtag,
  output logic                       arr_re,
  output logic                       line_we,
  output cache_pkg::word_t           line_wdata,
  output cache_pkg::line_idx_t       line_idx,
  output cache_pkg::cache_tag_t      line_tag,
  output logic                       tlb_load,
  output cache_pkg::tlb_entry_s      tlb_entry,
  output logic                       fill_start,
  output logic                       fill_step,
  output logic                       mem_start,
  output cache_pkg::mem_cmd_s        mem_cmd
);
  import cache_pkg::*;

  ctrl_state_e state;
  cpu_req_s    req_q;                        // accepted request
  logic        inhibit_q;
  logic        accept;
  logic        hit_ret;
  logic        word_bit;                     // offset of the word being written
  logic        next_bit;                     // offset of the word to fetch

  assign accept   = (state == IDLE) && (cpu_enable || tlb_we);
  assign hit_ret  = (state == CHECK) && !fault && !req_q.we && !inhibit_q && hit;
  assign req_vtag = req_q.addr[31:16];

  // ------------------------------
  // state and handshake flags
  // ------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state     <= IDLE;
      cpu_busy  <= 1'b0;
      mmu_fault <= 1'b0;
      vmem      <= 1'b0;
      inhibit_q <= 1'b0;
    end
    else
    begin
      case (state)
        IDLE:
          if (cpu_enable)                    // cache access wins over tlb_we
          begin
            vmem      <= vmem_act;
            inhibit_q <= cache_inhibit;
            cpu_busy  <= 1'b1;
            mmu_fault <= 1'b0;
            state     <= LOOKUP;
          end
          else if (tlb_we)
          begin
            cpu_busy  <= 1'b1;
            mmu_fault <= 1'b0;
            state     <= TLB_LOAD;
          end
        LOOKUP:
          state <= CHECK;
        CHECK:
          if (fault)
          begin
            mmu_fault <= 1'b1;
            cpu_busy  <= 1'b0;
            state     <= IDLE;
          end
          else if (req_q.we)
            state <= WRITE_MEM;
          else if (inhibit_q)
            state <= BYPASS;
          else if (hit)
          begin
            cpu_busy <= 1'b0;
            state    <= IDLE;
          end
          else
            state <= FILL;
        WRITE_MEM, BYPASS:
          if (mem_done)
          begin
            cpu_busy <= 1'b0;
            state    <= IDLE;
          end
        FILL:
          if (mem_done && fill_last)         // pair word is in
          begin
            cpu_busy <= 1'b0;
            state    <= IDLE;
          end
        TLB_LOAD:
        begin
          cpu_busy <= 1'b0;
          state    <= IDLE;
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  // request and returned word
  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
      req_q <= cpu_req;
    if (hit_ret)
      cpu_rdata <= line_data;
    else if (mem_done && (state == BYPASS))
      cpu_rdata <= mem_rdata_cap;
    else if (mem_done && (state == FILL) && !fill_last)
      cpu_rdata <= mem_rdata_cap;             // first fill word is the requested one
  end

  // ------------------------------
  // array and memory strobes
  // ------------------------------
  always_comb
  begin
    word_bit   = (state == FILL) ? fill_offset : req_q.addr[0];
    next_bit   = (state == FILL) ? ~fill_offset : req_q.addr[0];
    line_idx   = {req_q.addr[7:1], word_bit};
    line_tag   = {ptag, req_q.addr[15:8]};
    line_wdata = (state == FILL) ? mem_rdata_cap : req_q.wdata;
    arr_re     = (state == LOOKUP);
    tlb_load   = (state == TLB_LOAD);
    tlb_entry.ptag = req_q.wdata[31:16];
    tlb_entry.vtag = req_q.wdata[15:0];
    mem_cmd.addr   = {ptag, req_q.addr[15:1], next_bit};
    mem_cmd.wdata  = req_q.wdata;
    mem_cmd.we     = req_q.we;
    line_we    = 1'b0;
    fill_start = 1'b0;
    fill_step  = 1'b0;
    mem_start  = 1'b0;
    case (state)
      CHECK:
        if (!fault)
        begin
          if (req_q.we)
          begin
            mem_start = 1'b1;
            line_we   = !inhibit_q;            // line updated as the write starts
          end
          else if (inhibit_q)
            mem_start = 1'b1;
          else if (!hit)
          begin
            mem_start  = 1'b1;
            fill_start = 1'b1;
          end
        end
      FILL:
        if (mem_done)
        begin
          line_we = 1'b1;
          if (!fill_last)
          begin
            fill_step = 1'b1;
            mem_start = 1'b1;                  // fetch the pair word
          end
        end
      default:
        line_we = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* design/snowball_cache_top.sv */
// ------------------------------
// cache top level. CPU enable/busy port on one side, four-phase
// memory port on the other, arrays and FSM in between
// ------------------------------
`default_nettype none

module snowball_cache_top (
  input  wire logic                 CPU_CLK,
  input  wire logic                 RST,
  input  wire logic                 cpu_enable,
  input  wire cache_pkg::cpu_req_s  cpu_req,
  input  wire logic                 tlb_we,
  input  wire logic                 vmem_act,
  input  wire logic                 cache_inhibit,
  input  wire logic                 mem_ack,
  input  wire cache_pkg::word_t     mem_rdata,
  output logic                      cpu_busy,
  output cache_pkg::word_t          cpu_rdata,
  output logic                      mmu_fault,
  output logic                      mem_req,
  output cache_pkg::mem_cmd_s       mem_cmd
);
  import cache_pkg::*;

  logic       hit;
  logic       fault;
  logic       vmem;
  logic       arr_re;
  logic       line_we;
  logic       tlb_load;
  logic       fill_start;
  logic       fill_step;
  logic       fill_offset;
  logic       fill_last;
  logic       mem_start;
  logic       mem_done;
  page_tag_t  ptag;
  page_tag_t  req_vtag;
  word_t      line_data;
  word_t      line_wdata;
  word_t      mem_rdata_cap;
  line_idx_t  line_idx;
  cache_tag_t line_tag;
  tlb_entry_s tlb_entry;
  mem_cmd_s   ctrl_cmd;

  cache_ctrl u_ctrl (
    .CPU_CLK(CPU_CLK), .RST(RST), .cpu_enable(cpu_enable), .cpu_req(cpu_req),
    .tlb_we(tlb_we), .vmem_act(vmem_act), .cache_inhibit(cache_inhibit),
    .hit(hit), .fault(fault), .ptag(ptag), .mem_done(mem_done),
    .mem_rdata_cap(mem_rdata_cap), .fill_offset(fill_offset), .fill_last(fill_last),
    .line_data(line_data), .cpu_busy(cpu_busy), .cpu_rdata(cpu_rdata),
    .mmu_fault(mmu_fault), .vmem(vmem), .req_vtag(req_vtag), .arr_re(arr_re),
    .line_we(line_we), .line_wdata(line_wdata), .line_idx(line_idx),
    .line_tag(line_tag), .tlb_load(tlb_load), .tlb_entry(tlb_entry),
    .fill_start(fill_start), .fill_step(fill_step), .mem_start(mem_start),
    .mem_cmd(ctrl_cmd)
  );

  cache_store u_store (
    .CPU_CLK(CPU_CLK), .RST(RST), .re(arr_re), .rd_idx(line_idx),
    .want_tag(line_tag), .we(line_we), .wr_idx(line_idx), .wr_tag(line_tag),
    .wr_data(line_wdata), .rd_data(line_data), .hit(hit)
  );

  // tlb index is the low byte of the line tag
  tlb_store u_tlb (
    .CPU_CLK(CPU_CLK), .re(arr_re), .rd_idx(line_tag[7:0]), .vtag(req_vtag),
    .vmem(vmem), .we(tlb_load), .wr_idx(line_tag[7:0]), .wr_entry(tlb_entry),
    .ptag(ptag), .fault(fault)
  );

  fill_counter u_fill (
    .CPU_CLK(CPU_CLK), .RST(RST), .start(fill_start), .first_offset(line_idx[0]),
    .step(fill_step), .offset(fill_offset), .last(fill_last)
  );

  mem_port u_mem (
    .CPU_CLK(CPU_CLK), .RST(RST), .start(mem_start), .cmd_in(ctrl_cmd),
    .mem_ack(mem_ack), .mem_rdata(mem_rdata), .mem_cmd(mem_cmd),
    .mem_req(mem_req), .done(mem_done), .rdata_cap(mem_rdata_cap)
  );

endmodule

`default_nettype wire

/* tb/mem_model.sv */
// ------------------------------
// behavioral memory for the cache testbench. answers the four-phase
// handshake after 1 to 4 cycles and may keep ack high a few cycles
// after req falls. counts reads and writes
// ------------------------------
`default_nettype none

module mem_model (
  input  wire logic                 CPU_CLK,
  input  wire logic                 mem_req,
  input  wire cache_pkg::mem_cmd_s  mem_cmd,
  output logic                      mem_ack,
  output cache_pkg::word_t          mem_rdata,
  output int                        rd_count,
  output int                        wr_count,
  output cache_pkg::paddr_t         last_rd_addr,
  output cache_pkg::paddr_t         prev_rd_addr,
  output cache_pkg::paddr_t         last_wr_addr,
  output cache_pkg::word_t          last_wr_data
);
  timeunit 1ns;
  timeprecision 100ps;
  import cache_pkg::*;

  word_t mem [paddr_t];                       // sparse contents
  int    seed;
  int    ack_wait;
  int    ack_hold;

  initial
  begin
    seed         = 32'hbe32bd0c;
    mem_ack      = 1'b0;
    mem_rdata    = '0;
    rd_count     = 0;
    wr_count     = 0;
    last_rd_addr = '0;
    prev_rd_addr = '0;
    last_wr_addr = '0;
    last_wr_data = '0;
    forever
    begin
      @(posedge CPU_CLK);
      #1;
      if (mem_req && !mem_ack)
      begin
        ack_wait = 1 + ($random(seed) & 3);   // 1 to 4 cycles
        repeat (ack_wait)
        begin
          @(posedge CPU_CLK);
          #1;
        end
        if (mem_cmd.we)
        begin
          mem[mem_cmd.addr] = mem_cmd.wdata;
          last_wr_addr      = mem_cmd.addr;
          last_wr_data      = mem_cmd.wdata;
          wr_count++;
        end
        else
        begin
          // unwritten words read as the inverted address
          mem_rdata    = mem.exists(mem_cmd.addr) ? mem[mem_cmd.addr] : ~mem_cmd.addr;
          prev_rd_addr = last_rd_addr;
          last_rd_addr = mem_cmd.addr;
          rd_count++;
        end
        mem_ack = 1'b1;
        while (mem_req)                       // hold ack until req drops
        begin
          @(posedge CPU_CLK);
          #1;
        end
        ack_hold = $random(seed) & 3;         // released 0 to 3 cycles late
        repeat (ack_hold)
        begin
          @(posedge CPU_CLK);
          #1;
        end
        mem_ack = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* tb/cache_tb.sv */
// ------------------------------
// testbench for the cache top level. runs CPU accesses against a
// reference of memory, TLB and cache lines, checks every access
// when busy falls and watches the memory handshake
// ------------------------------
`default_nettype none

module cache_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import cache_pkg::*;

  localparam int RANDOM_OPS = 24;
  localparam int ACCESSES   = 12 + RANDOM_OPS;   // directed plus random

  logic     CPU_CLK;
  logic     RST;
  logic     cpu_enable;
  cpu_req_s cpu_req;
  logic     tlb_we;
  logic     vmem_act;
  logic     cache_inhibit;
  logic     mem_ack;
  word_t    mem_rdata;
  logic     cpu_busy;
  word_t    cpu_rdata;
  logic     mmu_fault;
  logic     mem_req;
  mem_cmd_s mem_cmd;
  int       rd_count;
  int       wr_count;
  paddr_t   last_rd_addr;
  paddr_t   prev_rd_addr;
  paddr_t   last_wr_addr;
  word_t    last_wr_data;
  int       seed;

  // reference state
  word_t      mem_ref [paddr_t];
  tlb_entry_s tlb_ref [TLB_ENTRIES];
  bit         ref_valid [LINES];
  cache_tag_t ref_tag [LINES];
  word_t      ref_data [LINES];

  snowball_cache_top u_dut (
    .CPU_CLK(CPU_CLK), .RST(RST), .cpu_enable(cpu_enable), .cpu_req(cpu_req),
    .tlb_we(tlb_we), .vmem_act(vmem_act), .cache_inhibit(cache_inhibit),
    .mem_ack(mem_ack), .mem_rdata(mem_rdata), .cpu_busy(cpu_busy),
    .cpu_rdata(cpu_rdata), .mmu_fault(mmu_fault), .mem_req(mem_req), .mem_cmd(mem_cmd)
  );

  mem_model u_mem (
    .CPU_CLK(CPU_CLK), .mem_req(mem_req), .mem_cmd(mem_cmd), .mem_ack(mem_ack),
    .mem_rdata(mem_rdata), .rd_count(rd_count), .wr_count(wr_count),
    .last_rd_addr(last_rd_addr), .prev_rd_addr(prev_rd_addr),
    .last_wr_addr(last_wr_addr), .last_wr_data(last_wr_data)
  );

  initial CPU_CLK = 1'b0;
  always #4 CPU_CLK = ~CPU_CLK;               // 8 ns period

  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string test, input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act == exp)
    else
    begin
      $display("FAIL %s %s: expected %h, actual %h", test, what, exp, act);
      abort_run();
    end
  endtask

  // ------------------------------
  // memory handshake rules
  // ------------------------------
  req_rise_a: assert property (@(posedge CPU_CLK) disable iff (!RST)
                               $rose(mem_req) |-> !$past(mem_ack))
  else
  begin
    $display("memory handshake broken: mem_req rose while mem_ack was high");
    abort_run();
  end

  cmd_stable_a: assert property (@(posedge CPU_CLK) disable iff (!RST)
                                 (mem_req || mem_ack) |=> $stable(mem_cmd))
  else
  begin
    $display("memory handshake broken: mem_cmd changed during a transfer");
    abort_run();
  end

  // ------------------------------
  // reference model
  // ------------------------------
  function automatic word_t mem_word(input paddr_t pa);
    return mem_ref.exists(pa) ? mem_ref[pa] : ~pa;
  endfunction

  function automatic paddr_t phys_addr(input vaddr_t a, input logic vm);
    return vm ? {tlb_ref[a[15:8]].ptag, a[15:0]} : a;
  endfunction

  task automatic update_line(input vaddr_t a, input paddr_t pa, input word_t d);
    ref_valid[a[7:0]] = 1'b1;
    ref_tag[a[7:0]]   = {pa[31:16], a[15:8]};   // physical tag and TLB index
    ref_data[a[7:0]]  = d;
  endtask

  // one access, returns cycles from acceptance to the fall of busy
  task automatic run_access(input logic tlb, input logic we, input vaddr_t a, input word_t d,
                            input logic vm, input logic inh, output int lat);
    cpu_req.addr  = a;
    cpu_req.wdata = d;
    cpu_req.we    = we;
    cpu_enable    = !tlb;
    tlb_we        = tlb;
    vmem_act      = vm;
    cache_inhibit = inh;
    @(posedge CPU_CLK);
    #1;
    cpu_enable = 1'b0;
    tlb_we     = 1'b0;
    lat        = 0;
    while (cpu_busy)
    begin
      @(posedge CPU_CLK);
      #1;
      lat++;
    end
  endtask

  task automatic read_and_check(input string test, input vaddr_t a, input logic vm,
                                input logic inh);
    paddr_t pa;
    logic   hit_exp;
    word_t  exp;
    int     r0;
    int     lat;
    pa      = phys_addr(a, vm);
    hit_exp = !inh && ref_valid[a[7:0]] && (ref_tag[a[7:0]] == {pa[31:16], a[15:8]});
    exp     = hit_exp ? ref_data[a[7:0]] : mem_word(pa);
    r0      = rd_count;
    run_access(1'b0, 1'b0, a, '0, vm, inh, lat);
    check_value(test, "read data", exp, cpu_rdata);
    check_value(test, "fault flag", 32'd0, 32'(mmu_fault));
    check_value(test, "memory reads", inh ? 32'd1 : (hit_exp ? 32'd0 : 32'd2), rd_count - r0);
    if (hit_exp)
      check_value(test, "hit latency", 32'd2, lat);
    else if (inh)
      check_value(test, "bypass address", pa, last_rd_addr);
    else
    begin
      check_value(test, "first fill address", pa, prev_rd_addr);
      check_value(test, "pair fill address", pa ^ 32'd1, last_rd_addr);
      update_line(a, pa, mem_word(pa));
      update_line(a ^ 32'd1, pa ^ 32'd1, mem_word(pa ^ 32'd1));
    end
  endtask

  task automatic write_and_check(input string test, input vaddr_t a, input word_t d);
    int r0;
    int w0;
    int lat;
    r0 = rd_count;
    w0 = wr_count;
    run_access(1'b0, 1'b1, a, d, 1'b0, 1'b0, lat);
    check_value(test, "memory writes", 32'd1, wr_count - w0);
    check_value(test, "memory reads", 32'd0, rd_count - r0);
    check_value(test, "write address", a, last_wr_addr);
    check_value(test, "write data", d, last_wr_data);
    mem_ref[a] = d;
    update_line(a, a, d);                     // write-through also fills the line
  endtask

  task automatic load_tlb_entry(input string test, input tlb_idx_t idx, input page_tag_t p,
                                input page_tag_t v);
    int lat;
    run_access(1'b1, 1'b0, {16'h0, idx, 8'h0}, {p, v}, 1'b0, 1'b0, lat);
    check_value(test, "tlb load latency", 32'd1, lat);
    tlb_ref[idx].ptag = p;
    tlb_ref[idx].vtag = v;
  endtask

  task automatic expect_fault(input string test, input vaddr_t a);
    int r0;
    int w0;
    int lat;
    r0 = rd_count;
    w0 = wr_count;
    run_access(1'b0, 1'b0, a, '0, 1'b1, 1'b0, lat);
    check_value(test, "fault flag", 32'd1, 32'(mmu_fault));
    check_value(test, "fault latency", 32'd2, lat);
    check_value(test, "memory requests", 32'd0, (rd_count - r0) + (wr_count - w0));
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------
  initial
  begin : stimulus
    logic [31:0] r;
    int          i;
    seed          = 32'hbe32bd0c;
    RST           = 1'b0;
    cpu_enable    = 1'b0;
    tlb_we        = 1'b0;
    vmem_act      = 1'b0;
    cache_inhibit = 1'b0;
    cpu_req       = '0;
    repeat (16) @(posedge CPU_CLK);
    #1;
    RST = 1'b1;

    read_and_check("miss_then_hit", 32'h0000_0a31, 1'b0, 1'b0);
    read_and_check("miss_then_hit", 32'h0000_0a31, 1'b0, 1'b0);
    read_and_check("miss_then_hit", 32'h0000_0a30, 1'b0, 1'b0);   // pair word
    write_and_check("write_through", 32'h0000_0b44, 32'hcafe_f00d);
    read_and_check("write_through", 32'h0000_0b44, 1'b0, 1'b0);
    load_tlb_entry("translation", 8'h12, 16'h5a5a, 16'h1234);
    read_and_check("translation", 32'h1234_1206, 1'b1, 1'b0);
    expect_fault("mmu_fault", 32'h9999_1206);
    read_and_check("mmu_fault", 32'h1234_1207, 1'b1, 1'b0);        // clears the fault
    repeat (3) read_and_check("cache_inhibit", 32'h0000_0c10, 1'b0, 1'b1);

    // a few lines with four competing tags
    for (i = 0; i < RANDOM_OPS; i++)
    begin
      r = $random(seed);
      if (r[31])
        write_and_check("random", {16'h0, 6'h0, r[9:8], 4'h0, r[3:0]}, $random(seed));
      else
        read_and_check("random", {16'h0, 6'h0, r[9:8], 4'h0, r[3:0]}, 1'b0, 1'b0);
    end

    $display("RESULT: PASS");
    $finish;
  end

  initial
  begin : watchdog
    repeat (ACCESSES * 40 + 200) @(posedge CPU_CLK);
    $display("timeout: the accesses did not finish in the expected number of cycles");
    abort_run();
  end

endmodule

`default_nettype wire

/* verilog.f */
common/cache_pkg.sv
design/fill_counter.sv
design/mem_port.sv
design/tlb_store.sv
cache/cache_store.sv
cache/cache_ctrl.sv
design/snowball_cache_top.sv
tb/mem_model.sv
tb/cache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the cache testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module cache_tb -f verilog.f -o cache_sim

output=$(./obj_dir/cache_sim 2>&1 || true)
echo "$output"
if grep -qx "RESULT: PASS" <<< "$output"; then
  exit 0
fi
exit 1
